// File: logic/apb_reg_bridge.sv
// APB slave state machine that turns each APB transfer into one register-bus request
`timescale 1ns/10ps

module apb_reg_bridge #(
   parameter int APB_ADDR_WIDTH = 12
) (
   input  logic                             clk_i,
   input  logic                             rst_n_i,

   // APB slave port
   input  logic                             psel_i,
   input  logic                             penable_i,
   input  logic                             pwrite_i,
   input  logic [APB_ADDR_WIDTH-1:0]        paddr_i,
   input  logic [soc_ctrl_pkg::REG_DW-1:0]  pwdata_i,
   output logic [soc_ctrl_pkg::REG_DW-1:0]  prdata_o,
   output logic                             pready_o,
   output logic                             pslverr_o,

   // register bus request
   output logic                             req_valid_o,
   output soc_ctrl_pkg::reg_op_e            req_op_o,
   output logic [APB_ADDR_WIDTH-1:0]        req_addr_o,
   output logic [soc_ctrl_pkg::REG_DW-1:0]  req_wdata_o,

   // register bus response, one cycle after the request
   input  logic [soc_ctrl_pkg::REG_DW-1:0]  rsp_rdata_i,
   input  logic                             rsp_error_i
);

   import soc_ctrl_pkg::*;

   apb_state_e state_q;
   apb_state_e state_cur;
   apb_state_e state_d;

   // the first access cycle is already the issue cycle, so idle falls through
   // to issue without waiting for a clock edge
   always_comb begin
      state_cur = state_q;
      if (state_q == APB_IDLE && psel_i && penable_i) begin
         state_cur = APB_ISSUE;
      end
   end

   always_comb begin
      case (state_cur)
         APB_IDLE:  state_d = APB_IDLE;
         APB_ISSUE: state_d = APB_RESP;
         APB_RESP:  state_d = APB_IDLE;
         default:   state_d = APB_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= APB_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // one request per transfer, carrying the address and data the master holds stable
   assign req_valid_o = (state_cur == APB_ISSUE);
   assign req_op_o    = pwrite_i ? REG_OP_WRITE : REG_OP_READ;
   assign req_addr_o  = paddr_i;
   assign req_wdata_o = pwdata_i;

   // response goes out with pready in the second access cycle
   assign pready_o = (state_cur == APB_RESP);

   // prdata and pslverr stay low outside the response cycle
   always_comb begin
      prdata_o  = '0;
      pslverr_o = 1'b0;
      if (state_cur == APB_RESP) begin
         prdata_o  = rsp_rdata_i;
         pslverr_o = rsp_error_i;
      end
   end

endmodule

// File: logic/apb_soc_control.sv
// SoC control top level joining the APB bridge, register file and LLC event counters
`timescale 1ns/10ps

module apb_soc_control #(
   parameter int APB_ADDR_WIDTH = 12,
   parameter int CNT_WIDTH      = 32
) (
   input  logic                             clk_i,
   input  logic                             rst_n_i,

   // APB slave port
   input  logic                             psel_i,
   input  logic                             penable_i,
   input  logic                             pwrite_i,
   input  logic [APB_ADDR_WIDTH-1:0]        paddr_i,
   input  logic [soc_ctrl_pkg::REG_DW-1:0]  pwdata_i,
   output logic [soc_ctrl_pkg::REG_DW-1:0]  prdata_o,
   output logic                             pready_o,
   output logic                             pslverr_o,

   // cluster control
   output logic                             cluster_ctrl_rstn_o,
   output logic                             cluster_en_sa_boot_o,
   output logic                             cluster_fetch_en_o,

   // LLC address windows
   output logic [soc_ctrl_pkg::REG_DW-1:0]  llc_cache_addr_start_o,
   output logic [soc_ctrl_pkg::REG_DW-1:0]  llc_cache_addr_end_o,
   output logic [soc_ctrl_pkg::REG_DW-1:0]  llc_spm_addr_start_o,

   // LLC events
   input  logic                             llc_read_hit_cache_i,
   input  logic                             llc_read_miss_cache_i,
   input  logic                             llc_write_hit_cache_i,
   input  logic                             llc_write_miss_cache_i
);

   import soc_ctrl_pkg::*;

   logic                       req_valid;
   reg_op_e                    req_op;
   logic [APB_ADDR_WIDTH-1:0]  req_addr;
   logic [REG_DW-1:0]          req_wdata;
   logic [REG_DW-1:0]          rsp_rdata;
   logic                       rsp_error;

   logic                       cnt_en;
   logic [CNT_WIDTH-1:0]       cnt_rd_hit;
   logic [CNT_WIDTH-1:0]       cnt_rd_miss;
   logic [CNT_WIDTH-1:0]       cnt_wr_hit;
   logic [CNT_WIDTH-1:0]       cnt_wr_miss;

   apb_reg_bridge #(
      .APB_ADDR_WIDTH ( APB_ADDR_WIDTH )
   ) i_apb_reg_bridge (
      .clk_i       ( clk_i       ),
      .rst_n_i     ( rst_n_i     ),
      .psel_i      ( psel_i      ),
      .penable_i   ( penable_i   ),
      .pwrite_i    ( pwrite_i    ),
      .paddr_i     ( paddr_i     ),
      .pwdata_i    ( pwdata_i    ),
      .prdata_o    ( prdata_o    ),
      .pready_o    ( pready_o    ),
      .pslverr_o   ( pslverr_o   ),
      .req_valid_o ( req_valid   ),
      .req_op_o    ( req_op      ),
      .req_addr_o  ( req_addr    ),
      .req_wdata_o ( req_wdata   ),
      .rsp_rdata_i ( rsp_rdata   ),
      .rsp_error_i ( rsp_error   )
   );

   soc_ctrl_regfile #(
      .APB_ADDR_WIDTH ( APB_ADDR_WIDTH ),
      .CNT_WIDTH      ( CNT_WIDTH      )
   ) i_soc_ctrl_regfile (
      .clk_i                  ( clk_i                  ),
      .rst_n_i                ( rst_n_i                ),
      .req_valid_i            ( req_valid              ),
      .req_op_i               ( req_op                 ),
      .req_addr_i             ( req_addr               ),
      .req_wdata_i            ( req_wdata              ),
      .rsp_rdata_o            ( rsp_rdata              ),
      .rsp_error_o            ( rsp_error              ),
      .cnt_rd_hit_i           ( cnt_rd_hit             ),
      .cnt_rd_miss_i          ( cnt_rd_miss            ),
      .cnt_wr_hit_i           ( cnt_wr_hit             ),
      .cnt_wr_miss_i          ( cnt_wr_miss            ),
      .cnt_en_o               ( cnt_en                 ),
      .cluster_ctrl_rstn_o    ( cluster_ctrl_rstn_o    ),
      .cluster_en_sa_boot_o   ( cluster_en_sa_boot_o   ),
      .cluster_fetch_en_o     ( cluster_fetch_en_o     ),
      .llc_cache_addr_start_o ( llc_cache_addr_start_o ),
      .llc_cache_addr_end_o   ( llc_cache_addr_end_o   ),
      .llc_spm_addr_start_o   ( llc_spm_addr_start_o   )
   );

   llc_event_counters #(
      .CNT_WIDTH ( CNT_WIDTH )
   ) i_llc_event_counters (
      .clk_i                  ( clk_i                  ),
      .rst_n_i                ( rst_n_i                ),
      .cnt_en_i               ( cnt_en                 ),
      .llc_read_hit_cache_i   ( llc_read_hit_cache_i   ),
      .llc_read_miss_cache_i  ( llc_read_miss_cache_i  ),
      .llc_write_hit_cache_i  ( llc_write_hit_cache_i  ),
      .llc_write_miss_cache_i ( llc_write_miss_cache_i ),
      .cnt_rd_hit_o           ( cnt_rd_hit             ),
      .cnt_rd_miss_o          ( cnt_rd_miss            ),
      .cnt_wr_hit_o           ( cnt_wr_hit             ),
      .cnt_wr_miss_o          ( cnt_wr_miss            )
   );

endmodule

// File: logic/llc_event_counters.sv
// four enabled LLC event counters for read and write hits and misses
`timescale 1ns/10ps

module llc_event_counters #(
   parameter int CNT_WIDTH = 32
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   // count enable from the register file
   input  logic                  cnt_en_i,

   // single-cycle event pulses from the cache
   input  logic                  llc_read_hit_cache_i,
   input  logic                  llc_read_miss_cache_i,
   input  logic                  llc_write_hit_cache_i,
   input  logic                  llc_write_miss_cache_i,

   // running counts
   output logic [CNT_WIDTH-1:0]  cnt_rd_hit_o,
   output logic [CNT_WIDTH-1:0]  cnt_rd_miss_o,
   output logic [CNT_WIDTH-1:0]  cnt_wr_hit_o,
   output logic [CNT_WIDTH-1:0]  cnt_wr_miss_o
);

   localparam int NUM_EVT    = 4;
   localparam int EVT_RD_HIT  = 0;
   localparam int EVT_RD_MISS = 1;
   localparam int EVT_WR_HIT  = 2;
   localparam int EVT_WR_MISS = 3;

   logic [NUM_EVT-1:0]    evt;
   logic [CNT_WIDTH-1:0]  cnt_q [NUM_EVT];

   always_comb begin
      evt              = '0;
      evt[EVT_RD_HIT]  = llc_read_hit_cache_i;
      evt[EVT_RD_MISS] = llc_read_miss_cache_i;
      evt[EVT_WR_HIT]  = llc_write_hit_cache_i;
      evt[EVT_WR_MISS] = llc_write_miss_cache_i;
   end

   // each counter wraps at its own width and clears only on reset
   for (genvar i = 0; i < NUM_EVT; i++) begin : g_cnt
      always_ff @(posedge clk_i) begin
         if (!rst_n_i) begin
            cnt_q[i] <= '0;
         end else if (cnt_en_i && evt[i]) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
         end
      end
   end

   assign cnt_rd_hit_o  = cnt_q[EVT_RD_HIT];
   assign cnt_rd_miss_o = cnt_q[EVT_RD_MISS];
   assign cnt_wr_hit_o  = cnt_q[EVT_WR_HIT];
   assign cnt_wr_miss_o = cnt_q[EVT_WR_MISS];

endmodule

// File: logic/soc_ctrl_pkg.sv
// register map, data width, register-bus opcodes and APB bridge states for the SoC control block
package soc_ctrl_pkg;

   // register data width, also the APB data width
   localparam int REG_DW = 32;

   // width of the decoded register index
   localparam int REG_IDX_W = 4;

   // word addresses at or beyond this count are unmapped
   localparam int NUM_REGS = 9;

   // byte offsets of the registers inside the APB window
   localparam int unsigned REG_CLUSTER_CTRL_OFFSET = 32'h00;
   localparam int unsigned REG_CACHE_START_OFFSET  = 32'h04;
   localparam int unsigned REG_CACHE_END_OFFSET    = 32'h08;
   localparam int unsigned REG_SPM_START_OFFSET    = 32'h0C;
   localparam int unsigned REG_CNT_EN_OFFSET       = 32'h10;
   localparam int unsigned REG_RD_HIT_OFFSET       = 32'h14;
   localparam int unsigned REG_RD_MISS_OFFSET      = 32'h18;
   localparam int unsigned REG_WR_HIT_OFFSET       = 32'h1C;
   localparam int unsigned REG_WR_MISS_OFFSET      = 32'h20;

   // bit positions inside the cluster control register
   localparam int CTRL_RSTN_BIT  = 0;
   localparam int CTRL_BOOT_BIT  = 1;
   localparam int CTRL_FETCH_BIT = 2;
   localparam int CTRL_W         = 3;

   // register index is the word address, so each value is its offset divided by four
   typedef enum logic [REG_IDX_W-1:0] {
      REG_CLUSTER_CTRL = REG_IDX_W'(REG_CLUSTER_CTRL_OFFSET >> 2),
      REG_CACHE_START  = REG_IDX_W'(REG_CACHE_START_OFFSET >> 2),
      REG_CACHE_END    = REG_IDX_W'(REG_CACHE_END_OFFSET >> 2),
      REG_SPM_START    = REG_IDX_W'(REG_SPM_START_OFFSET >> 2),
      REG_CNT_EN       = REG_IDX_W'(REG_CNT_EN_OFFSET >> 2),
      // the four counter registers are read-only
      REG_RD_HIT       = REG_IDX_W'(REG_RD_HIT_OFFSET >> 2),
      REG_RD_MISS      = REG_IDX_W'(REG_RD_MISS_OFFSET >> 2),
      REG_WR_HIT       = REG_IDX_W'(REG_WR_HIT_OFFSET >> 2),
      REG_WR_MISS      = REG_IDX_W'(REG_WR_MISS_OFFSET >> 2)
   } soc_reg_e;

   // opcodes on the internal register bus
   typedef enum logic {
      REG_OP_READ  = 1'b0,
      REG_OP_WRITE = 1'b1
   } reg_op_e;

   // APB slave bridge states
   typedef enum logic [1:0] {
      APB_IDLE  = 2'd0,
      APB_ISSUE = 2'd1,
      APB_RESP  = 2'd2
   } apb_state_e;

endpackage

// File: logic/soc_ctrl_regfile.sv
// control and LLC address registers with address decode, read mux and access error generation
`timescale 1ns/10ps

module soc_ctrl_regfile #(
   parameter int APB_ADDR_WIDTH = 12,
   parameter int CNT_WIDTH      = 32
) (
   input  logic                             clk_i,
   input  logic                             rst_n_i,

   // register bus
   input  logic                             req_valid_i,
   input  soc_ctrl_pkg::reg_op_e            req_op_i,
   input  logic [APB_ADDR_WIDTH-1:0]        req_addr_i,
   input  logic [soc_ctrl_pkg::REG_DW-1:0]  req_wdata_i,
   output logic [soc_ctrl_pkg::REG_DW-1:0]  rsp_rdata_o,
   output logic                             rsp_error_o,

   // event counters
   input  logic [CNT_WIDTH-1:0]             cnt_rd_hit_i,
   input  logic [CNT_WIDTH-1:0]             cnt_rd_miss_i,
   input  logic [CNT_WIDTH-1:0]             cnt_wr_hit_i,
   input  logic [CNT_WIDTH-1:0]             cnt_wr_miss_i,
   output logic                             cnt_en_o,

   // cluster control
   output logic                             cluster_ctrl_rstn_o,
   output logic                             cluster_en_sa_boot_o,
   output logic                             cluster_fetch_en_o,

   // LLC address windows
   output logic [soc_ctrl_pkg::REG_DW-1:0]  llc_cache_addr_start_o,
   output logic [soc_ctrl_pkg::REG_DW-1:0]  llc_cache_addr_end_o,
   output logic [soc_ctrl_pkg::REG_DW-1:0]  llc_spm_addr_start_o
);

   import soc_ctrl_pkg::*;

   // width of the word address above the byte offset
   localparam int WA_W = APB_ADDR_WIDTH - 2;

   logic [WA_W-1:0]    word_addr;
   logic               misaligned;
   logic               mapped;
   soc_reg_e           reg_sel;
   logic               is_write;
   logic               is_cnt_reg;
   logic               acc_err;
   logic               wr_ok;
   logic [REG_DW-1:0]  rd_val;

   logic [CTRL_W-1:0]  ctrl_q;
   logic [REG_DW-1:0]  cache_start_q;
   logic [REG_DW-1:0]  cache_end_q;
   logic [REG_DW-1:0]  spm_start_q;
   logic               cnt_en_q;

   logic [REG_DW-1:0]  rsp_rdata_q;
   logic               rsp_error_q;

   // decode the request address into a register index
   always_comb begin
      word_addr  = req_addr_i[APB_ADDR_WIDTH-1:2];
      misaligned = |req_addr_i[1:0];
      mapped     = (word_addr < WA_W'(NUM_REGS));
      reg_sel    = soc_reg_e'(word_addr[REG_IDX_W-1:0]);
      is_write   = (req_op_i == REG_OP_WRITE);
      is_cnt_reg = reg_sel inside {REG_RD_HIT, REG_RD_MISS, REG_WR_HIT, REG_WR_MISS};
      acc_err    = misaligned || !mapped || (is_write && is_cnt_reg);
      wr_ok      = req_valid_i && is_write && !acc_err;
   end

   // read mux, counters are zero-extended to the bus width
   always_comb begin
      rd_val = '0;
      case (reg_sel)
         REG_CLUSTER_CTRL: rd_val[CTRL_W-1:0] = ctrl_q;
         REG_CACHE_START:  rd_val = cache_start_q;
         REG_CACHE_END:    rd_val = cache_end_q;
         REG_SPM_START:    rd_val = spm_start_q;
         REG_CNT_EN:       rd_val[0] = cnt_en_q;
         REG_RD_HIT:       rd_val = REG_DW'(cnt_rd_hit_i);
         REG_RD_MISS:      rd_val = REG_DW'(cnt_rd_miss_i);
         REG_WR_HIT:       rd_val = REG_DW'(cnt_wr_hit_i);
         REG_WR_MISS:      rd_val = REG_DW'(cnt_wr_miss_i);
         default:          rd_val = '0;
      endcase
   end

   // writable registers, a write replaces the whole register
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_q        <= '0;
         cache_start_q <= '0;
         cache_end_q   <= '0;
         spm_start_q   <= '0;
         cnt_en_q      <= 1'b0;
      end else if (wr_ok) begin
         case (reg_sel)
            REG_CLUSTER_CTRL: ctrl_q        <= req_wdata_i[CTRL_W-1:0];
            REG_CACHE_START:  cache_start_q <= req_wdata_i;
            REG_CACHE_END:    cache_end_q   <= req_wdata_i;
            REG_SPM_START:    spm_start_q   <= req_wdata_i;
            REG_CNT_EN:       cnt_en_q      <= req_wdata_i[0];
            default:          ;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rsp_error_q <= 1'b0;
      end else if (req_valid_i) begin
         rsp_error_q <= acc_err;
      end
   end

   // writes and failed accesses answer with zero data
   always_ff @(posedge clk_i) begin
      if (req_valid_i) begin
         rsp_rdata_q <= (acc_err || is_write) ? '0 : rd_val;
      end
   end

   assign rsp_rdata_o = rsp_rdata_q;
   assign rsp_error_o = rsp_error_q;

   assign cnt_en_o = cnt_en_q;

   assign cluster_ctrl_rstn_o  = ctrl_q[CTRL_RSTN_BIT];
   assign cluster_en_sa_boot_o = ctrl_q[CTRL_BOOT_BIT];
   assign cluster_fetch_en_o   = ctrl_q[CTRL_FETCH_BIT];

   assign llc_cache_addr_start_o = cache_start_q;
   assign llc_cache_addr_end_o   = cache_end_q;
   assign llc_spm_addr_start_o   = spm_start_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
   --top-module tb_apb_soc_control -Mdir obj_dir -f tb.f

output=$(./obj_dir/Vtb_apb_soc_control)
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
   exit 0
fi
exit 1

// File: tb.f
logic/soc_ctrl_pkg.sv
logic/apb_reg_bridge.sv
logic/soc_ctrl_regfile.sv
logic/llc_event_counters.sv
logic/apb_soc_control.sv
tests/soc_ctrl_checker.sv
tests/tb_apb_soc_control.sv

// File: tests/soc_ctrl_checker.sv
// testbench checker with register shadow, tally of LLC events, reference response and error counts
`timescale 1ns/10ps

module soc_ctrl_checker #(
   parameter int APB_ADDR_WIDTH = 12,
   parameter int CNT_WIDTH      = 32
) (
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   // APB as seen at the DUT
   input  logic                             psel_i,
   input  logic                             penable_i,
   input  logic                             pwrite_i,
   input  logic [APB_ADDR_WIDTH-1:0]        paddr_i,
   input  logic [soc_ctrl_pkg::REG_DW-1:0]  pwdata_i,
   input  logic [soc_ctrl_pkg::REG_DW-1:0]  prdata_i,
   input  logic                             pready_i,
   input  logic                             pslverr_i,
   // chip outputs, cluster bits as {fetch_en, en_sa_boot, reset_n}
   input  logic [2:0]                       cluster_i,
   input  logic [soc_ctrl_pkg::REG_DW-1:0]  cache_start_i,
   input  logic [soc_ctrl_pkg::REG_DW-1:0]  cache_end_i,
   input  logic [soc_ctrl_pkg::REG_DW-1:0]  spm_start_i,
   // LLC events as {write miss, write hit, read miss, read hit}
   input  logic [3:0]                       events_i,
   output int                               value_errs_o,
   output int                               proto_errs_o
);

   import soc_ctrl_pkg::*;

   // the DUT counters wrap at 2**CNT_WIDTH
   localparam logic [REG_DW-1:0] CNT_MASK = REG_DW'((64'd1 << CNT_WIDTH) - 64'd1);

   logic [2:0]         ctrl_sh;
   logic [REG_DW-1:0]  cache_start_sh;
   logic [REG_DW-1:0]  cache_end_sh;
   logic [REG_DW-1:0]  spm_start_sh;
   logic               cnt_en_sh;
   logic [REG_DW-1:0]  tally [4];
   logic [REG_DW:0]    exp_rsp;
   logic               write_now;
   int                 access_cycles;
   int                 value_errs = 0;
   int                 proto_errs = 0;

   // expected {pslverr, prdata} for an access to addr
   function automatic logic [REG_DW:0] ref_response(input logic [APB_ADDR_WIDTH-1:0] addr,
                                                    input logic wr);
      logic [REG_DW-1:0] data;
      logic              read_only;
      logic              err;
      data      = '0;
      read_only = 1'b0;
      err       = 1'b0;
      case (32'(addr))
         REG_CLUSTER_CTRL_OFFSET: data = REG_DW'(ctrl_sh);
         REG_CACHE_START_OFFSET:  data = cache_start_sh;
         REG_CACHE_END_OFFSET:    data = cache_end_sh;
         REG_SPM_START_OFFSET:    data = spm_start_sh;
         REG_CNT_EN_OFFSET:       data = REG_DW'(cnt_en_sh);
         REG_RD_HIT_OFFSET:       {read_only, data} = {1'b1, tally[0] & CNT_MASK};
         REG_RD_MISS_OFFSET:      {read_only, data} = {1'b1, tally[1] & CNT_MASK};
         REG_WR_HIT_OFFSET:       {read_only, data} = {1'b1, tally[2] & CNT_MASK};
         REG_WR_MISS_OFFSET:      {read_only, data} = {1'b1, tally[3] & CNT_MASK};
         // misaligned and unmapped addresses land here
         default:                 err = 1'b1;
      endcase
      if (wr && read_only) begin
         err = 1'b1;
      end
      if (err || wr) begin
         data = '0;
      end
      return {err, data};
   endfunction

   task automatic shadow_write(input logic [APB_ADDR_WIDTH-1:0] addr,
                               input logic [REG_DW-1:0] data);
      case (32'(addr))
         REG_CLUSTER_CTRL_OFFSET: ctrl_sh        = data[2:0];
         REG_CACHE_START_OFFSET:  cache_start_sh = data;
         REG_CACHE_END_OFFSET:    cache_end_sh   = data;
         REG_SPM_START_OFFSET:    spm_start_sh   = data;
         REG_CNT_EN_OFFSET:       cnt_en_sh      = data[0];
         default:                 ;
      endcase
   endtask

   task automatic check_value(input string name, input logic [REG_DW-1:0] expected,
                              input logic [REG_DW-1:0] actual);
      if (expected !== actual) begin
         $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
         value_errs++;
      end
   endtask

   // inputs change just after the rising edge, so the falling edge sees them settled
   always @(negedge clk_i) begin
      write_now = 1'b0;
      if (!rst_n_i) begin
         ctrl_sh        = '0;
         cache_start_sh = '0;
         cache_end_sh   = '0;
         spm_start_sh   = '0;
         cnt_en_sh      = 1'b0;
         access_cycles  = 0;
         for (int i = 0; i < 4; i++) begin
            tally[i] = '0;
         end
      end else begin
         check_value("cluster_ctrl_rstn_o", REG_DW'(ctrl_sh[0]), REG_DW'(cluster_i[0]));
         check_value("cluster_en_sa_boot_o", REG_DW'(ctrl_sh[1]), REG_DW'(cluster_i[1]));
         check_value("cluster_fetch_en_o", REG_DW'(ctrl_sh[2]), REG_DW'(cluster_i[2]));
         check_value("llc_cache_addr_start_o", cache_start_sh, cache_start_i);
         check_value("llc_cache_addr_end_o", cache_end_sh, cache_end_i);
         check_value("llc_spm_addr_start_o", spm_start_sh, spm_start_i);
         if (!pready_i) begin
            check_value("prdata_o", '0, prdata_i);
            check_value("pslverr_o", '0, REG_DW'(pslverr_i));
         end
         if (psel_i && penable_i && !pready_i) begin
            access_cycles++;
            if (access_cycles == 1) begin
               // the register is sampled at the edge that ends this cycle
               exp_rsp   = ref_response(paddr_i, pwrite_i);
               write_now = pwrite_i;
            end else begin
               $display("Error at %0t: no pready within two access cycles for address %h",
                        $time, paddr_i);
               proto_errs++;
            end
         end else if (pready_i) begin
            if (!(psel_i && penable_i) || access_cycles != 1) begin
               $display("Error at %0t: pready came outside the second access cycle", $time);
               proto_errs++;
            end
            check_value("prdata_o", exp_rsp[REG_DW-1:0], prdata_i);
            check_value("pslverr_o", REG_DW'(exp_rsp[REG_DW]), REG_DW'(pslverr_i));
            access_cycles = 0;
         end
         // events seen now are counted at the next rising edge
         if (cnt_en_sh) begin
            for (int i = 0; i < 4; i++) begin
               if (events_i[i]) begin
                  tally[i] = tally[i] + 32'd1;
               end
            end
         end
         if (write_now) begin
            shadow_write(paddr_i, pwdata_i);
         end
      end
   end

   assign value_errs_o = value_errs;
   assign proto_errs_o = proto_errs;

endmodule

// File: tests/tb_apb_soc_control.sv
// testbench top with clock, reset, APB read and write tasks, LLC event stimulus and timeout
`timescale 1ns/10ps

module tb_apb_soc_control;

   localparam int APB_ADDR_WIDTH = 12;
   localparam int CNT_WIDTH      = 32;
   localparam int N_MIX          = 200;
   // transfers in the directed tests before the random mix
   localparam int N_DIRECTED     = 90;
   // setup, two access cycles and the idle cycle before the next setup
   localparam int XFER_CYCLES    = 4;
   localparam int MAX_GAP        = 4;
   localparam int BURST_CYCLES   = 150;
   localparam int CYCLE_LIMIT    =
      2 * (2 + (N_DIRECTED + N_MIX) * XFER_CYCLES + N_MIX * MAX_GAP + BURST_CYCLES);
   localparam logic [APB_ADDR_WIDTH-1:0] CNT_EN_ADDR = 'h10;

   logic                       clk_i;
   logic                       rst_n_i;
   logic                       psel_i;
   logic                       penable_i;
   logic                       pwrite_i;
   logic [APB_ADDR_WIDTH-1:0]  paddr_i;
   logic [31:0]                pwdata_i;
   logic [31:0]                prdata_o;
   logic                       pready_o;
   logic                       pslverr_o;
   logic                       cluster_ctrl_rstn_o;
   logic                       cluster_en_sa_boot_o;
   logic                       cluster_fetch_en_o;
   logic [31:0]                llc_cache_addr_start_o;
   logic [31:0]                llc_cache_addr_end_o;
   logic [31:0]                llc_spm_addr_start_o;
   logic                       llc_read_hit_cache_i;
   logic                       llc_read_miss_cache_i;
   logic                       llc_write_hit_cache_i;
   logic                       llc_write_miss_cache_i;

   integer                     seed = 32'h9828388f;
   int                         cycles = 0;
   int                         value_errs;
   int                         proto_errs;
   int                         rnd;
   logic [APB_ADDR_WIDTH-1:0]  addr;

   apb_soc_control #(
      .APB_ADDR_WIDTH ( APB_ADDR_WIDTH ),
      .CNT_WIDTH      ( CNT_WIDTH      )
   ) apb_soc_control_i (.*);

   soc_ctrl_checker #(
      .APB_ADDR_WIDTH ( APB_ADDR_WIDTH ),
      .CNT_WIDTH      ( CNT_WIDTH      )
   ) soc_ctrl_checker_i (
      .clk_i         ( clk_i                  ),
      .rst_n_i       ( rst_n_i                ),
      .psel_i        ( psel_i                 ),
      .penable_i     ( penable_i              ),
      .pwrite_i      ( pwrite_i               ),
      .paddr_i       ( paddr_i                ),
      .pwdata_i      ( pwdata_i               ),
      .prdata_i      ( prdata_o               ),
      .pready_i      ( pready_o               ),
      .pslverr_i     ( pslverr_o              ),
      .cluster_i     ( {cluster_fetch_en_o, cluster_en_sa_boot_o, cluster_ctrl_rstn_o} ),
      .cache_start_i ( llc_cache_addr_start_o ),
      .cache_end_i   ( llc_cache_addr_end_o   ),
      .spm_start_i   ( llc_spm_addr_start_o   ),
      .events_i      ( {llc_write_miss_cache_i, llc_write_hit_cache_i,
                        llc_read_miss_cache_i, llc_read_hit_cache_i} ),
      .value_errs_o  ( value_errs             ),
      .proto_errs_o  ( proto_errs             )
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the run stopped after %0d cycles before the tests finished", cycles);
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic apb_transfer(input logic wr, input logic [APB_ADDR_WIDTH-1:0] a,
                               input logic [31:0] data);
      int waits;
      waits = 0;
      @(posedge clk_i);
      #1;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = wr;
      paddr_i   = a;
      pwdata_i  = data;
      @(posedge clk_i);
      #1;
      penable_i = 1'b1;
      @(negedge clk_i);
      while (!pready_o && waits < 3) begin
         @(negedge clk_i);
         waits++;
      end
      @(posedge clk_i);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] a, input logic [31:0] data);
      apb_transfer(1'b1, a, data);
   endtask

   task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] a);
      apb_transfer(1'b0, a, '0);
   endtask

   // random event pulses for n cycles, then one quiet cycle
   task automatic event_burst(input int n);
      logic [3:0] pattern;
      for (int i = 0; i <= n; i++) begin
         @(posedge clk_i);
         #1;
         pattern = (i < n) ? 4'($random(seed)) : 4'b0000;
         {llc_write_miss_cache_i, llc_write_hit_cache_i,
          llc_read_miss_cache_i, llc_read_hit_cache_i} = pattern;
      end
   endtask

   task automatic read_regs(input int first, input int last);
      for (int i = first; i <= last; i++) begin
         apb_read(APB_ADDR_WIDTH'(4 * i));
      end
   endtask

   initial begin
      rst_n_i   = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      {llc_write_miss_cache_i, llc_write_hit_cache_i,
       llc_read_miss_cache_i, llc_read_hit_cache_i} = 4'b0000;
      repeat (2) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;

      // every register reads as zero after reset
      read_regs(0, 8);
      // control and address registers
      for (int k = 0; k < 12; k++) begin
         addr = APB_ADDR_WIDTH'(4 * ($unsigned($random(seed)) % 4));
         apb_write(addr, $random(seed));
         apb_read(addr);
      end
      // counters hold while disabled, count while enabled, freeze again once cleared
      event_burst(20);
      read_regs(5, 8);
      apb_write(CNT_EN_ADDR, 32'h1);
      for (int k = 0; k < 4; k++) begin
         event_burst(25);
         read_regs(5, 8);
      end
      apb_write(CNT_EN_ADDR, 32'h0);
      event_burst(20);
      read_regs(5, 8);
      // unmapped, counter and misaligned accesses
      for (int k = 0; k < 4; k++) begin
         addr = APB_ADDR_WIDTH'(4 * (9 + $unsigned($random(seed)) %
                                     ((1 << (APB_ADDR_WIDTH - 2)) - 9)));
         apb_write(addr, $random(seed));
         apb_read(addr);
         apb_write(APB_ADDR_WIDTH'(4 * (k + 5)), $random(seed));
         addr = APB_ADDR_WIDTH'(4 * ($unsigned($random(seed)) % 9) + 1 + k % 3);
         apb_write(addr, $random(seed));
         apb_read(addr);
      end
      read_regs(0, 8);
      // random traffic, the idle gaps carry events
      for (int k = 0; k < N_MIX; k++) begin
         rnd = $random(seed);
         if (rnd[1:0] != 2'b00) begin
            event_burst(int'(rnd[1:0]));
         end
         addr = APB_ADDR_WIDTH'(4 * (int'(rnd[7:4]) % 11));
         if (rnd[11:8] == 4'h0) begin
            addr[1:0] = rnd[13:12];
         end
         apb_transfer(rnd[2], addr, $random(seed));
      end

      repeat (4) @(posedge clk_i);
      $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
      if (value_errs == 0 && proto_errs == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
